//--- rv_dpath_pkg.sv
// ----------------------------------------------------------
// RISC-V datapath package
// Widths, select encodings and the stage payload structs
// ----------------------------------------------------------

package rv_dpath_pkg;

  localparam int xlen       = 32;  // Data and address width
  localparam int nregs      = 32;  // Architectural registers
  localparam int reg_addr_w = 5;   // Register specifier width

  // ----------------------------------------------------------
  // Select and function encodings
  // ----------------------------------------------------------

  typedef enum logic [1:0] {
    am_rdat = 2'd0,  // rs1 value
    am_zero = 2'd3   // Constant zero
  } op0_sel_e;

  typedef enum logic [2:0] {
    bm_rdat  = 3'd0,  // rs2 value
    bm_shamt = 3'd1,  // Shift amount field
    bm_imm_u = 3'd2,
    bm_imm_i = 3'd4,
    bm_imm_s = 3'd5,
    bm_zero  = 3'd6   // Code 3 was the old SB immediate
  } op1_sel_e;

  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_sll = 4'd2,
    alu_or  = 4'd3,
    alu_lt  = 4'd4,
    alu_ltu = 4'd5,
    alu_and = 4'd6,
    alu_xor = 4'd7,
    alu_nor = 4'd8,
    alu_srl = 4'd9,
    alu_sra = 4'd10
  } alu_fn_e;

  typedef enum logic [1:0] {
    mem_none  = 2'd0,
    mem_load  = 2'd1,
    mem_store = 2'd2
  } mem_op_e;

  typedef enum logic [2:0] {
    ld_w  = 3'd0,  // Full word
    ld_b  = 3'd1,  // Byte, sign extended
    ld_bu = 3'd2,  // Byte, zero extended
    ld_h  = 3'd3,  // Half, sign extended
    ld_hu = 3'd4   // Half, zero extended
  } load_kind_e;

  // ----------------------------------------------------------
  // Stage payloads and port bundles
  // ----------------------------------------------------------

  typedef struct packed {
    op0_sel_e   op0_sel;
    op1_sel_e   op1_sel;
    alu_fn_e    alu_fn;
    mem_op_e    mem_op;
    load_kind_e load_kind;
    logic       rf_wen;
  } dec_ctrl_t;

  typedef struct packed {
    logic [xlen-1:0]       op0;
    logic [xlen-1:0]       op1;
    logic [xlen-1:0]       st_data;  // rs2 value for stores
    logic [reg_addr_w-1:0] rd;
    alu_fn_e               alu_fn;
    mem_op_e               mem_op;
    load_kind_e            load_kind;
    logic                  rf_wen;
  } dx_pay_t;

  typedef struct packed {
    logic [xlen-1:0]       result;
    logic [reg_addr_w-1:0] rd;
    logic                  is_load;
    load_kind_e            load_kind;
    logic                  rf_wen;
    logic [1:0]            byte_off;  // Reserved, always zero
  } xm_pay_t;

  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic                  rf_wen;
    logic [xlen-1:0]       result;
  } mw_pay_t;

  typedef struct packed {
    logic            val;
    logic            wr;  // High for a store
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;
  } dmem_req_t;

  typedef struct packed {
    logic                  val;
    logic                  rf_wen;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
  } wb_t;

endpackage

//--- rv_regfile.sv
// ----------------------------------------------------------
// Register file
// Two read ports and one write-through write port
// ----------------------------------------------------------
`timescale 1ns/1ps

module rv_regfile (
  input  logic                              clk,
  input  logic [rv_dpath_pkg::reg_addr_w-1:0] raddr0,
  input  logic [rv_dpath_pkg::reg_addr_w-1:0] raddr1,
  output logic [rv_dpath_pkg::xlen-1:0]     rdata0,
  output logic [rv_dpath_pkg::xlen-1:0]     rdata1,
  input  logic                              wen,
  input  logic [rv_dpath_pkg::reg_addr_w-1:0] waddr,
  input  logic [rv_dpath_pkg::xlen-1:0]     wdata
);
  import rv_dpath_pkg::*;

  logic [xlen-1:0] regs [nregs];  // x0 masked on read

  // x0 reads zero ahead of any bypass of the write in flight
  function automatic logic [xlen-1:0] rd_port(input logic [reg_addr_w-1:0] addr);
    if (addr == '0) rd_port = '0;
    else if (wen && (addr == waddr)) rd_port = wdata;  // Write-through
    else rd_port = regs[addr];
  endfunction

  always_comb begin
    rdata0 = rd_port(raddr0);
    rdata1 = rd_port(raddr1);
  end

  always_ff @(posedge clk) begin
    if (wen && (waddr != '0)) regs[waddr] <= wdata;  // Drop writes to x0
  end

  // A write lands in storage and reads back on the next cycle
  write_reads_back: assert property (@(posedge clk)
    (wen && (waddr != '0)) |=>
      ((raddr0 != $past(waddr)) || (wen && (waddr == raddr0)) ||
       (rdata0 == $past(wdata))));

endmodule

//--- rv_decode.sv
// ----------------------------------------------------------
// Decode stage
// Field and immediate extraction, operand selection
// ----------------------------------------------------------
`timescale 1ns/1ps

module rv_decode (
  input  logic                                inst_val,
  input  logic [rv_dpath_pkg::xlen-1:0]       inst,
  input  rv_dpath_pkg::dec_ctrl_t             ctrl,
  output logic [rv_dpath_pkg::reg_addr_w-1:0] rf_raddr0,
  output logic [rv_dpath_pkg::reg_addr_w-1:0] rf_raddr1,
  input  logic [rv_dpath_pkg::xlen-1:0]       rf_rdata0,
  input  logic [rv_dpath_pkg::xlen-1:0]       rf_rdata1,
  output logic                                dx_val,
  output rv_dpath_pkg::dx_pay_t               dx
);
  import rv_dpath_pkg::*;

  logic [reg_addr_w-1:0] rs1, rs2, rd, shamt;
  logic [xlen-1:0]       imm_i, imm_s, imm_u;

  // ----------------------------------------------------------
  // Instruction fields
  // ----------------------------------------------------------

  assign rs1   = inst[19:15];
  assign rs2   = inst[24:20];
  assign rd    = inst[11:7];
  assign shamt = inst[24:20];  // Same bits as rs2

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'b0};  // Upper 20 bits, low zero

  // Register reads
  assign rf_raddr0 = rs1;
  assign rf_raddr1 = rs2;

  // ----------------------------------------------------------
  // Operand muxes and payload
  // ----------------------------------------------------------

  always_comb begin
    dx           = '0;
    dx.st_data   = rf_rdata1;  // Store data is always rs2
    dx.rd        = rd;
    dx.alu_fn    = ctrl.alu_fn;
    dx.mem_op    = ctrl.mem_op;
    dx.load_kind = ctrl.load_kind;
    dx.rf_wen    = ctrl.rf_wen;

    case (ctrl.op0_sel)
      am_rdat: dx.op0 = rf_rdata0;
      default: dx.op0 = '0;  // am_zero
    endcase

    case (ctrl.op1_sel)
      bm_rdat:  dx.op1 = rf_rdata1;
      bm_shamt: dx.op1 = {{(xlen-reg_addr_w){1'b0}}, shamt};
      bm_imm_u: dx.op1 = imm_u;
      bm_imm_i: dx.op1 = imm_i;
      bm_imm_s: dx.op1 = imm_s;
      default:  dx.op1 = '0;  // bm_zero
    endcase
  end

  assign dx_val = inst_val;  // Accept is gated by stall in the stage reg

  // Unused SB code must not reach the operand mux
  always_comb begin
    op1_sel_defined: assert final (!inst_val || (ctrl.op1_sel inside
      {bm_rdat, bm_shamt, bm_imm_u, bm_imm_i, bm_imm_s, bm_zero}));
  end

endmodule

//--- rv_stage_reg.sv
// ----------------------------------------------------------
// Pipeline register with valid bit
// Holds on stall, payload type set by parameter
// ----------------------------------------------------------
`timescale 1ns/1ps

module rv_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,
  input  logic     in_val,
  input  payload_t in_pay,
  output logic     out_val,
  output payload_t out_pay
);

  always_ff @(posedge clk) begin
    if (reset) out_val <= 1'b0;
    else if (!stall) out_val <= in_val;
  end

  // Payload has no reset
  always_ff @(posedge clk) begin
    if (!stall) out_pay <= in_pay;
  end

  pay_known: assert property (@(posedge clk) disable iff (reset)
    out_val |-> !$isunknown(out_pay));

endmodule

//--- rv_execute.sv
// ----------------------------------------------------------
// Execute stage
// ALU and data-memory request
// ----------------------------------------------------------
`timescale 1ns/1ps

module rv_execute (
  input  logic                    x_val,
  input  rv_dpath_pkg::dx_pay_t   x,
  output rv_dpath_pkg::xm_pay_t   xm,
  output rv_dpath_pkg::dmem_req_t dmem_req
);
  import rv_dpath_pkg::*;

  logic [4:0]      sh;       // Shift amount
  logic [xlen-1:0] alu_out;

  assign sh = x.op1[4:0];

  // ----------------------------------------------------------
  // ALU
  // ----------------------------------------------------------

  always_comb begin
    case (x.alu_fn)
      alu_add: alu_out = x.op0 + x.op1;
      alu_sub: alu_out = x.op0 - x.op1;
      alu_sll: alu_out = x.op0 << sh;
      alu_or:  alu_out = x.op0 | x.op1;
      alu_lt:  alu_out = {{(xlen-1){1'b0}}, ($signed(x.op0) < $signed(x.op1))};
      alu_ltu: alu_out = {{(xlen-1){1'b0}}, (x.op0 < x.op1)};
      alu_and: alu_out = x.op0 & x.op1;
      alu_xor: alu_out = x.op0 ^ x.op1;
      alu_nor: alu_out = ~(x.op0 | x.op1);
      alu_srl: alu_out = x.op0 >> sh;
      alu_sra: alu_out = $unsigned($signed(x.op0) >>> sh);  // Arithmetic
      default: alu_out = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Memory request, sent in this stage
  // ----------------------------------------------------------

  always_comb begin
    dmem_req.val  = x_val && (x.mem_op != mem_none);
    dmem_req.wr   = (x.mem_op == mem_store);
    dmem_req.addr = alu_out;    // Effective address
    dmem_req.data = x.st_data;
  end

  // Payload to memory stage
  always_comb begin
    xm.result    = alu_out;
    xm.rd        = x.rd;
    xm.is_load   = (x.mem_op == mem_load);
    xm.load_kind = x.load_kind;
    xm.rf_wen    = x.rf_wen;
    xm.byte_off  = 2'b00;  // Aligned accesses only
  end

endmodule

//--- rv_mem_wb.sv
// ----------------------------------------------------------
// Memory stage
// Load subword extension and writeback select
// ----------------------------------------------------------
`timescale 1ns/1ps

module rv_mem_wb (
  input  rv_dpath_pkg::xm_pay_t         m,
  input  logic [rv_dpath_pkg::xlen-1:0] dmem_resp_data,
  output rv_dpath_pkg::mw_pay_t         mw
);
  import rv_dpath_pkg::*;

  logic [xlen-1:0] resp_sh;  // Response moved to the low lanes
  logic [xlen-1:0] ld_data;

  assign resp_sh = dmem_resp_data >> {m.byte_off, 3'b000};

  always_comb begin
    case (m.load_kind)
      ld_b:    ld_data = {{24{resp_sh[7]}}, resp_sh[7:0]};
      ld_bu:   ld_data = {24'b0, resp_sh[7:0]};
      ld_h:    ld_data = {{16{resp_sh[15]}}, resp_sh[15:0]};
      ld_hu:   ld_data = {16'b0, resp_sh[15:0]};
      default: ld_data = resp_sh;  // Full word
    endcase
  end

  // Writeback mux
  always_comb begin
    mw.rd     = m.rd;
    mw.rf_wen = m.rf_wen;
    mw.result = m.is_load ? ld_data : m.result;
  end

endmodule

//--- rv_dpath.sv
// ----------------------------------------------------------
// RISC-V operand and result datapath, top level
// Decode, execute, memory and writeback around one stall
// ----------------------------------------------------------
`timescale 1ns/1ps

module rv_dpath (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          inst_val,
  input  logic [rv_dpath_pkg::xlen-1:0] inst,
  input  rv_dpath_pkg::dec_ctrl_t       ctrl,
  input  logic                          stall,
  output rv_dpath_pkg::dmem_req_t       dmem_req,
  input  logic [rv_dpath_pkg::xlen-1:0] dmem_resp_data,
  output rv_dpath_pkg::wb_t             wb
);
  import rv_dpath_pkg::*;

  logic [reg_addr_w-1:0] rf_raddr0, rf_raddr1;
  logic [xlen-1:0]       rf_rdata0, rf_rdata1;

  logic    d_val, x_val, m_val, w_val;  // Valid per stage
  dx_pay_t d_pay, x_pay;
  xm_pay_t xm_pay, m_pay;
  mw_pay_t mw_pay, w_pay;

  // ----------------------------------------------------------
  // Stages
  // ----------------------------------------------------------

  rv_decode u_decode (
    .inst_val(inst_val), .inst(inst), .ctrl(ctrl),
    .rf_raddr0(rf_raddr0), .rf_raddr1(rf_raddr1),
    .rf_rdata0(rf_rdata0), .rf_rdata1(rf_rdata1),
    .dx_val(d_val), .dx(d_pay)
  );

  rv_stage_reg #(.payload_t(dx_pay_t)) u_dx_reg (
    .clk(clk), .reset(reset), .stall(stall),
    .in_val(d_val), .in_pay(d_pay), .out_val(x_val), .out_pay(x_pay)
  );

  rv_execute u_execute (.x_val(x_val), .x(x_pay), .xm(xm_pay), .dmem_req(dmem_req));

  rv_stage_reg #(.payload_t(xm_pay_t)) u_xm_reg (
    .clk(clk), .reset(reset), .stall(stall),
    .in_val(x_val), .in_pay(xm_pay), .out_val(m_val), .out_pay(m_pay)
  );

  rv_mem_wb u_mem_wb (.m(m_pay), .dmem_resp_data(dmem_resp_data), .mw(mw_pay));

  rv_stage_reg #(.payload_t(mw_pay_t)) u_mw_reg (
    .clk(clk), .reset(reset), .stall(stall),
    .in_val(m_val), .in_pay(mw_pay), .out_val(w_val), .out_pay(w_pay)
  );

  // Writeback port straight from the last stage register
  assign wb = '{val: w_val, rf_wen: w_pay.rf_wen, rd: w_pay.rd, data: w_pay.result};

  rv_regfile u_regfile (
    .clk(clk),
    .raddr0(rf_raddr0), .raddr1(rf_raddr1),
    .rdata0(rf_rdata0), .rdata1(rf_rdata1),
    .wen(w_val && w_pay.rf_wen),  // Only valid instructions write
    .waddr(w_pay.rd), .wdata(w_pay.result)
  );

endmodule

//--- tb_rv_dpath.sv
// ----------------------------------------------------------
// Testbench for the RISC-V operand and result datapath
// Random stream, memory model, reference model and checker
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_rv_dpath;
  import rv_dpath_pkg::*;

  localparam int          clk_period  = 8;
  localparam int          n_instr     = 400;  // Includes the 31 register inits
  localparam int          timeout_ns  = (n_instr * 8 + 40) * clk_period;
  localparam logic [31:0] mem_pattern = 32'h5a3c_96e1;  // Memory word is addr ^ this

  logic            clk, reset, inst_val, stall;
  logic [xlen-1:0] inst, dmem_resp_data;
  dec_ctrl_t       ctrl;
  dmem_req_t       dmem_req;
  wb_t             wb;

  logic [31:0]     lcg_state = 32'h3239_c43f;
  logic [31:0]     model_regs [nregs];      // Architectural reference state
  logic [4:0]      last_rd0, last_rd1;      // rd of the two last accepted
  wb_t             exp_wb_q [$];
  dmem_req_t       exp_req_q [$];
  int              wb_count = 0;
  op1_sel_e        op1_pick [6] = '{bm_rdat, bm_shamt, bm_imm_u, bm_imm_i, bm_imm_s, bm_zero};

  rv_dpath dut (.clk(clk), .reset(reset), .inst_val(inst_val), .inst(inst), .ctrl(ctrl),
    .stall(stall), .dmem_req(dmem_req), .dmem_resp_data(dmem_resp_data), .wb(wb));

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1);
  endtask

  // Sequential model of one accepted instruction
  function automatic void ref_model(input logic [31:0] in, input dec_ctrl_t c,
                                    output wb_t exp_wb, output dmem_req_t exp_req);
    logic [31:0] a, b, res, word, wdat;
    logic [63:0] wide;
    logic [4:0]  sh;
    a = (c.op0_sel == am_rdat) ? model_regs[in[19:15]] : 32'd0;
    case (c.op1_sel)
      bm_rdat:  b = model_regs[in[24:20]];
      bm_shamt: b = {27'd0, in[24:20]};
      bm_imm_u: b = {in[31:12], 12'd0};
      bm_imm_i: b = {{20{in[31]}}, in[31:20]};
      bm_imm_s: b = {{20{in[31]}}, in[31:25], in[11:7]};
      default:  b = 32'd0;
    endcase
    sh   = b[4:0];
    wide = {{32{a[31]}}, a} >> sh;  // Sign fill for sra
    case (c.alu_fn)
      alu_add: res = a + b;
      alu_sub: res = a + ~b + 32'd1;
      alu_sll: res = a << sh;
      alu_or:  res = a | b;
      alu_lt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_ltu: res = (a < b) ? 32'd1 : 32'd0;
      alu_and: res = a & b;
      alu_xor: res = a ^ b;
      alu_nor: res = ~(a | b);
      alu_srl: res = a >> sh;
      alu_sra: res = wide[31:0];
      default: res = 32'd0;
    endcase
    word = res ^ mem_pattern;  // What the memory model returns
    case (c.load_kind)
      ld_b:    wdat = 32'($signed(word[7:0]));
      ld_bu:   wdat = 32'(word[7:0]);
      ld_h:    wdat = 32'($signed(word[15:0]));
      ld_hu:   wdat = 32'(word[15:0]);
      default: wdat = word;
    endcase
    if (c.mem_op != mem_load) wdat = res;
    exp_req = '{val: (c.mem_op != mem_none), wr: (c.mem_op == mem_store), addr: res,
                data: model_regs[in[24:20]]};
    exp_wb  = '{val: 1'b1, rf_wen: c.rf_wen, rd: in[11:7], data: wdat};
    if (c.rf_wen && in[11:7] != 5'd0) model_regs[in[11:7]] = wdat;  // x0 stays zero
  endfunction

  // First 31 write every register, then random ops with hazard spacing
  task automatic gen_instr(input int idx, output logic [31:0] in, output dec_ctrl_t c);
    logic [31:0] r1, r2;
    logic [4:0]  rs1, rs2;
    int          m;
    r1 = rand32();
    r2 = rand32();
    if (idx < nregs - 1) begin
      in = {r1[31:25], 10'd0, r1[24:22], 5'(idx + 1), r1[21:15]};  // rs1 = rs2 = x0
      c  = '{op0_sel: am_zero, op1_sel: bm_imm_i, alu_fn: alu_add, mem_op: mem_none,
             load_kind: ld_w, rf_wen: 1'b1};
    end else begin
      in          = {r1[31:16], r2[31:16]};
      m           = int'(r1[15:12]);
      c.op0_sel   = (r2[15:13] == 3'd0) ? am_zero : am_rdat;
      c.op1_sel   = op1_pick[int'(r1[11:5]) % 6];
      c.alu_fn    = alu_fn_e'(4'(int'(r2[12:5]) % 11));
      c.mem_op    = (m < 4) ? mem_load : ((m < 7) ? mem_store : mem_none);
      c.load_kind = load_kind_e'(3'(int'(r2[4:1]) % 5));
      c.rf_wen    = (r1[4:2] != 3'd0);
      if (r2[31:29] == 3'd0) in[11:7] = 5'd0;  // Some writes aimed at x0
      rs1 = in[19:15];
      rs2 = in[24:20];
      while (rs1 != 5'd0 && (rs1 == last_rd0 || rs1 == last_rd1)) rs1 = rs1 + 5'd1;
      while (rs2 != 5'd0 && (rs2 == last_rd0 || rs2 == last_rd1)) rs2 = rs2 + 5'd1;
      in[19:15] = rs1;
      in[24:20] = rs2;
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------

  initial begin : stimulus
    logic [31:0] r, next_inst;
    dec_ctrl_t   next_ctrl;
    wb_t         exp_wb;
    dmem_req_t   exp_req;
    int          n_sent;
    reset = 1'b1;
    inst_val = 1'b0;
    inst = '0;
    ctrl = '0;
    stall = 1'b0;
    dmem_resp_data = '0;
    last_rd0 = 5'd0;
    last_rd1 = 5'd0;
    n_sent = 0;
    foreach (model_regs[i]) model_regs[i] = 32'd0;
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
    repeat (4) begin  // Idle pipeline stays quiet
      @(negedge clk);
      check_eq("wb.val", 32'd0, 32'(wb.val));
      check_eq("dmem_req.val", 32'd0, 32'(dmem_req.val));
    end
    gen_instr(0, next_inst, next_ctrl);
    while (n_sent < n_instr) begin
      @(posedge clk);
      #1;
      r        = rand32();
      stall    = (int'(r[23:16]) % 100) < 15;
      inst_val = (int'(r[31:24]) % 100) >= 20;
      inst     = next_inst;   // Held until accepted
      ctrl     = next_ctrl;
      if (inst_val && !stall) begin  // Taken at the coming edge
        ref_model(next_inst, next_ctrl, exp_wb, exp_req);
        exp_wb_q.push_back(exp_wb);
        if (exp_req.val) exp_req_q.push_back(exp_req);
        last_rd1 = last_rd0;
        last_rd0 = next_inst[11:7];
        n_sent++;
        gen_instr(n_sent, next_inst, next_ctrl);
      end
    end
    @(posedge clk);
    #1;
    inst_val = 1'b0;
    stall    = 1'b0;
    wait (wb_count == n_instr);
    @(negedge clk);
    if (exp_wb_q.size() == 0 && exp_req_q.size() == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      abort_run("Expected results left over after the last writeback");
    end
  end

  // Memory model, samples at advancing edges, holds under stall
  initial begin : mem_model
    logic        take;
    logic [31:0] next_resp;
    forever begin
      @(negedge clk);
      take      = !reset && !stall && dmem_req.val;
      next_resp = dmem_req.addr ^ mem_pattern;
      @(posedge clk);
      #1;
      if (take) dmem_resp_data = next_resp;
    end
  end

  // ----------------------------------------------------------
  // Compare, once per advancing cycle
  // ----------------------------------------------------------

  initial begin : compare
    wb_t       exp_wb;
    dmem_req_t exp_req;
    forever begin
      @(negedge clk);
      if (!reset && $isunknown({wb.val, dmem_req.val}))
        abort_run("Unknown valid on wb or dmem_req after reset");
      if (!reset && !stall && dmem_req.val) begin
        if (exp_req_q.size() == 0) abort_run("Memory request with no load or store pending");
        exp_req = exp_req_q.pop_front();
        check_eq("dmem_req.wr", 32'(exp_req.wr), 32'(dmem_req.wr));
        check_eq("dmem_req.addr", exp_req.addr, dmem_req.addr);
        check_eq("dmem_req.data", exp_req.data, dmem_req.data);
      end
      if (!reset && !stall && wb.val) begin
        if (exp_wb_q.size() == 0) abort_run("Writeback with no instruction in flight");
        exp_wb = exp_wb_q.pop_front();
        check_eq("wb.rf_wen", 32'(exp_wb.rf_wen), 32'(wb.rf_wen));
        check_eq("wb.rd", 32'(exp_wb.rd), 32'(wb.rd));
        check_eq("wb.data", exp_wb.data, wb.data);
        wb_count++;
      end
    end
  end

  initial begin : watchdog
    #(timeout_ns);
    abort_run("Timeout, the pipeline hung before all writebacks arrived");
  end

endmodule

//--- src.f
rv_dpath_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_stage_reg.sv
rv_execute.sv
rv_mem_wb.sv
rv_dpath.sv
tb_rv_dpath.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_rv_dpath \
  -o sim_rv_dpath > build.log 2>&1 \
  && ./obj_dir/sim_rv_dpath > sim.log 2>&1
cat build.log sim.log 2> /dev/null | tail -n 20
grep -qx "Done: no errors" sim.log 2> /dev/null && echo "PASS" \
  || { echo "FAIL"; exit 1; }
